// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the issue pipeline testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_issue_core -o tb_issue_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_issue_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: sim.f
+incdir+source
source/issue_pkg.sv
source/instr_decode.sv
source/reg_file.sv
source/alu_execute.sv
source/result_stage.sv
source/issue_core.sv
tests/issue_monitor.sv
tests/issue_core_checker.sv
tests/tb_issue_core.sv

// File: source/alu_execute.sv
// Execute stage with its input register and the RV32I integer ALU

`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module alu_execute (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       dec_valid,
    input  wire issue_pkg::operand_t  dec_in1,
    input  wire issue_pkg::operand_t  dec_in2,
    input  wire issue_pkg::word_t     dec_shift_in,
    input  wire issue_pkg::alu_fn_t   dec_fn,
    input  wire                       dec_sub,
    input  wire                       dec_arith,
    input  wire issue_pkg::word_t     dec_pc,
    input  wire issue_pkg::reg_addr_t dec_rd,
    input  wire                       dec_illegal,
    output logic                      dec_ready,
    output logic                      ex_valid,
    output issue_pkg::word_t          ex_pc,
    output issue_pkg::reg_addr_t      ex_rd,
    output issue_pkg::word_t          ex_value,
    output logic                      ex_illegal,
    input  wire                       ex_ready
);

    issue_pkg::operand_t in1_q;
    issue_pkg::operand_t in2_q;
    issue_pkg::word_t    shift_q;
    issue_pkg::alu_fn_t  fn_q;
    logic                sub_q;
    logic                arith_q;

    logic                subtract;
    issue_pkg::operand_t sum;
    issue_pkg::operand_t sr_wide;
    logic [4:0]          shamt;

    ////////////////////////////////////////
    // Stage register
    assign dec_ready = ~ex_valid | ex_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (dec_ready) begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            in1_q      <= dec_in1;
            in2_q      <= dec_in2;
            shift_q    <= dec_shift_in;
            fn_q       <= dec_fn;
            sub_q      <= dec_sub;
            arith_q    <= dec_arith;
            ex_pc      <= dec_pc;
            ex_rd      <= dec_rd;
            ex_illegal <= dec_illegal;
        end
    end

    ////////////////////////////////////////
    // ALU
    // Compares reuse the adder as a subtract
    assign subtract = sub_q | (fn_q == `FN3_SLT) | (fn_q == `FN3_SLTU);
    assign sum = in1_q + (in2_q ^ {(`XLEN+1){subtract}}) + {{`XLEN{1'b0}}, subtract};

    assign shamt   = in2_q[4:0];
    assign sr_wide = $signed({arith_q, shift_q}) >>> shamt;

    always_comb begin
        case (fn_q)
            `FN3_SLL:  ex_value = shift_q << shamt;
            `FN3_SLT,
            `FN3_SLTU: ex_value = {{(`XLEN-1){1'b0}}, sum[`XLEN]};
            `FN3_XOR:  ex_value = in1_q[`XLEN-1:0] ^ in2_q[`XLEN-1:0];
            `FN3_SR:   ex_value = sr_wide[`XLEN-1:0];
            `FN3_OR:   ex_value = in1_q[`XLEN-1:0] | in2_q[`XLEN-1:0];
            `FN3_AND:  ex_value = in1_q[`XLEN-1:0] & in2_q[`XLEN-1:0];
            default:   ex_value = sum[`XLEN-1:0];
        endcase
    end

endmodule

`default_nettype wire

// File: source/instr_decode.sv
// Decode stage of the issue pipeline
// Instruction register, legality check, scoreboard stall and operand build

`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module instr_decode (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      in_valid,
    input  wire issue_pkg::word_t    in_instr,
    input  wire issue_pkg::word_t    in_pc,
    output logic                     in_ready,
    output issue_pkg::reg_addr_t     rs1_addr,
    output issue_pkg::reg_addr_t     rs2_addr,
    input  wire issue_pkg::word_t    rs1_data,
    input  wire issue_pkg::word_t    rs2_data,
    input  wire                      rs1_pending,
    input  wire                      rs2_pending,
    input  wire                      rd_pending,
    output logic                     issue_set,
    output issue_pkg::reg_addr_t     issue_rd,
    output logic                     dec_valid,
    output issue_pkg::operand_t      dec_in1,
    output issue_pkg::operand_t      dec_in2,
    output issue_pkg::word_t         dec_shift_in,
    output issue_pkg::alu_fn_t       dec_fn,
    output logic                     dec_sub,
    output logic                     dec_arith,
    output issue_pkg::word_t         dec_pc,
    output issue_pkg::reg_addr_t     dec_rd,
    output logic                     dec_illegal,
    input  wire                      dec_ready
);

    logic                 held_valid;
    issue_pkg::word_t     held_instr;
    issue_pkg::word_t     held_pc;

    logic [4:0]           opc_trim;
    logic                 opc_ok;
    issue_pkg::alu_fn_t   fn3;
    logic [6:0]           funct7;
    issue_pkg::reg_addr_t rd;

    logic is_lui;
    logic is_auipc;
    logic is_op;
    logic is_op_imm;
    logic uses_rs1;
    logic uses_rs2;
    logic illegal;
    logic hazard;
    logic issue;
    logic is_sltu;

    issue_pkg::word_t src1;
    issue_pkg::word_t src2;

    ////////////////////////////////////////
    // Instruction register
    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (in_ready) begin
            held_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held_instr <= in_instr;
            held_pc    <= in_pc;
        end
    end

    // Field aliases
    assign opc_ok   = (held_instr[1:0] == 2'b11);
    assign opc_trim = held_instr[6:2];
    assign fn3      = held_instr[14:12];
    assign funct7   = held_instr[31:25];
    assign rd       = held_instr[11:7];
    assign rs1_addr = held_instr[19:15];
    assign rs2_addr = held_instr[24:20];

    assign is_lui    = opc_ok && (opc_trim == `OPC_LUI);
    assign is_auipc  = opc_ok && (opc_trim == `OPC_AUIPC);
    assign is_op     = opc_ok && (opc_trim == `OPC_OP);
    assign is_op_imm = opc_ok && (opc_trim == `OPC_OP_IMM);

    assign uses_rs1 = is_op | is_op_imm;
    assign uses_rs2 = is_op;

    // Only funct7 zero, or sub/sra with bit 30 set
    assign illegal = ~(is_lui | is_auipc | is_op | is_op_imm) |
                     (is_op && !((funct7 == 7'b0000000) ||
                                 ((funct7 == 7'b0100000) &&
                                  ((fn3 == `FN3_ADD) || (fn3 == `FN3_SR)))));

    ////////////////////////////////////////
    // Hazard stall and issue
    // rd_pending covers write-after-write
    assign hazard = (uses_rs1 & rs1_pending) | (uses_rs2 & rs2_pending) | rd_pending;

    assign dec_valid = held_valid & (illegal | ~hazard);
    assign issue     = dec_valid & dec_ready;
    assign in_ready  = ~held_valid | issue;

    // x0 never becomes pending
    assign issue_set = issue & ~illegal & (rd != '0);
    assign issue_rd  = rd;

    ////////////////////////////////////////
    // Operand build
    always_comb begin
        if (is_lui) begin
            src1 = '0;
        end else if (is_auipc) begin
            src1 = held_pc;
        end else begin
            src1 = rs1_data;
        end

        if (is_lui || is_auipc) begin
            src2 = {held_instr[31:12], 12'b0};
        end else if (is_op_imm) begin
            src2 = {{20{held_instr[31]}}, held_instr[31:20]};
        end else begin
            src2 = rs2_data;
        end
    end

    // LUI and AUIPC reuse the adder
    assign dec_fn  = (is_op || is_op_imm) ? fn3 : `FN3_ADD;
    assign is_sltu = (dec_fn == `FN3_SLTU);

    assign dec_in1      = {src1[`XLEN-1] & ~is_sltu, src1};
    assign dec_in2      = {src2[`XLEN-1] & ~is_sltu, src2};
    assign dec_shift_in = rs1_data;
    assign dec_sub      = is_op & held_instr[30] & (fn3 == `FN3_ADD);
    // Fill bit for right shifts
    assign dec_arith    = held_instr[30] & rs1_data[`XLEN-1];

    assign dec_pc      = held_pc;
    assign dec_rd      = rd;
    assign dec_illegal = illegal;

endmodule

`default_nettype wire

// File: source/issue_core.sv
// Top level of the issue pipeline
// Decode, execute and result stages around the register file

`timescale 1ns/1ps
`default_nettype none

module issue_core (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       in_valid,
    input  wire issue_pkg::word_t     in_instr,
    input  wire issue_pkg::word_t     in_pc,
    output logic                      in_ready,
    output logic                      res_valid,
    output issue_pkg::word_t          res_pc,
    output issue_pkg::reg_addr_t      res_rd,
    output issue_pkg::word_t          res_value,
    output logic                      res_illegal,
    input  wire                       res_ready
);

    // Register file port
    issue_pkg::reg_addr_t rs1_addr;
    issue_pkg::reg_addr_t rs2_addr;
    issue_pkg::word_t     rs1_data;
    issue_pkg::word_t     rs2_data;
    logic                 rs1_pending;
    logic                 rs2_pending;
    logic                 rd_pending;
    logic                 issue_set;
    issue_pkg::reg_addr_t issue_rd;
    logic                 wb_en;
    issue_pkg::reg_addr_t wb_rd;
    issue_pkg::word_t     wb_value;

    // Decode to execute
    logic                 dec_valid;
    logic                 dec_ready;
    issue_pkg::operand_t  dec_in1;
    issue_pkg::operand_t  dec_in2;
    issue_pkg::word_t     dec_shift_in;
    issue_pkg::alu_fn_t   dec_fn;
    logic                 dec_sub;
    logic                 dec_arith;
    issue_pkg::word_t     dec_pc;
    issue_pkg::reg_addr_t dec_rd;
    logic                 dec_illegal;

    // Execute to result
    logic                 ex_valid;
    logic                 ex_ready;
    issue_pkg::word_t     ex_pc;
    issue_pkg::reg_addr_t ex_rd;
    issue_pkg::word_t     ex_value;
    logic                 ex_illegal;

    instr_decode u_instr_decode (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .in_pc        (in_pc),
        .in_ready     (in_ready),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs1_pending  (rs1_pending),
        .rs2_pending  (rs2_pending),
        .rd_pending   (rd_pending),
        .issue_set    (issue_set),
        .issue_rd     (issue_rd),
        .dec_valid    (dec_valid),
        .dec_in1      (dec_in1),
        .dec_in2      (dec_in2),
        .dec_shift_in (dec_shift_in),
        .dec_fn       (dec_fn),
        .dec_sub      (dec_sub),
        .dec_arith    (dec_arith),
        .dec_pc       (dec_pc),
        .dec_rd       (dec_rd),
        .dec_illegal  (dec_illegal),
        .dec_ready    (dec_ready)
    );

    // The held rd of decode is both the pending lookup and the issue target
    reg_file u_reg_file (
        .clk         (clk),
        .rst         (rst),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_pending (rs1_pending),
        .rs2_pending (rs2_pending),
        .rd_addr     (issue_rd),
        .rd_pending  (rd_pending),
        .issue_set   (issue_set),
        .issue_rd    (issue_rd),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value)
    );

    alu_execute u_alu_execute (
        .clk          (clk),
        .rst          (rst),
        .dec_valid    (dec_valid),
        .dec_in1      (dec_in1),
        .dec_in2      (dec_in2),
        .dec_shift_in (dec_shift_in),
        .dec_fn       (dec_fn),
        .dec_sub      (dec_sub),
        .dec_arith    (dec_arith),
        .dec_pc       (dec_pc),
        .dec_rd       (dec_rd),
        .dec_illegal  (dec_illegal),
        .dec_ready    (dec_ready),
        .ex_valid     (ex_valid),
        .ex_pc        (ex_pc),
        .ex_rd        (ex_rd),
        .ex_value     (ex_value),
        .ex_illegal   (ex_illegal),
        .ex_ready     (ex_ready)
    );

    result_stage u_result_stage (
        .clk         (clk),
        .rst         (rst),
        .ex_valid    (ex_valid),
        .ex_pc       (ex_pc),
        .ex_rd       (ex_rd),
        .ex_value    (ex_value),
        .ex_illegal  (ex_illegal),
        .ex_ready    (ex_ready),
        .res_valid   (res_valid),
        .res_pc      (res_pc),
        .res_rd      (res_rd),
        .res_value   (res_value),
        .res_illegal (res_illegal),
        .res_ready   (res_ready),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value)
    );

endmodule

`default_nettype wire

// File: source/issue_params.svh
// Opcode, function code and width macros for the RV32I issue pipeline
// Opcodes are the trimmed instr[6:2] form

`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

`define XLEN        32
`define NUM_REGS    32

// Trimmed opcodes of the supported classes
`define OPC_LUI     5'b01101
`define OPC_AUIPC   5'b00101
`define OPC_OP      5'b01100
`define OPC_OP_IMM  5'b00100

// funct3 codes for OP and OP-IMM
`define FN3_ADD     3'b000
`define FN3_SLL     3'b001
`define FN3_SLT     3'b010
`define FN3_SLTU    3'b011
`define FN3_XOR     3'b100
`define FN3_SR      3'b101
`define FN3_OR      3'b110
`define FN3_AND     3'b111

`endif

// File: source/issue_pkg.sv
// Shared vector typedefs of the issue pipeline
// Data words, register indices, ALU function codes and compare operands

`default_nettype none

`include "issue_params.svh"

package issue_pkg;

    // Data word, PC or instruction
    typedef logic [`XLEN-1:0] word_t;

    // Register index
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;

    // ALU function, same encoding as funct3
    typedef logic [2:0] alu_fn_t;

    // Word plus one extension bit for signed/unsigned compare
    typedef logic [`XLEN:0] operand_t;

endpackage

`default_nettype wire

// File: source/reg_file.sv
// Register file of 32 words with x0 tied to zero
// Pending-write scoreboard, set at issue and cleared at write-back

`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module reg_file (
    input  wire                       clk,
    input  wire                       rst,
    input  wire issue_pkg::reg_addr_t rs1_addr,
    input  wire issue_pkg::reg_addr_t rs2_addr,
    output issue_pkg::word_t          rs1_data,
    output issue_pkg::word_t          rs2_data,
    output logic                      rs1_pending,
    output logic                      rs2_pending,
    input  wire issue_pkg::reg_addr_t rd_addr,
    output logic                      rd_pending,
    input  wire                       issue_set,
    input  wire issue_pkg::reg_addr_t issue_rd,
    input  wire                       wb_en,
    input  wire issue_pkg::reg_addr_t wb_rd,
    input  wire issue_pkg::word_t     wb_value
);

    issue_pkg::word_t      regs [`NUM_REGS];
    logic [`NUM_REGS-1:0]  pending;

    // Storage write
    always_ff @(posedge clk) begin
        if (wb_en && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_value;
        end
    end

    // Asynchronous read, x0 reads zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    ////////////////////////////////////////
    // Scoreboard
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (wb_en) begin
                pending[wb_rd] <= 1'b0;
            end
            if (issue_set && (issue_rd != '0)) begin
                pending[issue_rd] <= 1'b1;
            end
        end
    end

    assign rs1_pending = pending[rs1_addr];
    assign rs2_pending = pending[rs2_addr];
    assign rd_pending  = pending[rd_addr];

endmodule

`default_nettype wire

// File: source/result_stage.sv
// Result stage with the outward handshake and the write-back command

`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       ex_valid,
    input  wire issue_pkg::word_t     ex_pc,
    input  wire issue_pkg::reg_addr_t ex_rd,
    input  wire issue_pkg::word_t     ex_value,
    input  wire                       ex_illegal,
    output logic                      ex_ready,
    output logic                      res_valid,
    output issue_pkg::word_t          res_pc,
    output issue_pkg::reg_addr_t      res_rd,
    output issue_pkg::word_t          res_value,
    output logic                      res_illegal,
    input  wire                       res_ready,
    output logic                      wb_en,
    output issue_pkg::reg_addr_t      wb_rd,
    output issue_pkg::word_t          wb_value
);

    assign ex_ready = ~res_valid | res_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (ex_ready) begin
            res_valid <= ex_valid;
        end
    end

    // Illegal results report rd and value as zero
    always_ff @(posedge clk) begin
        if (ex_valid && ex_ready) begin
            res_pc      <= ex_pc;
            res_illegal <= ex_illegal;
            res_rd      <= ex_illegal ? '0 : ex_rd;
            res_value   <= ex_illegal ? '0 : ex_value;
        end
    end

    // Write back only once the result is taken
    assign wb_en    = res_valid & res_ready & ~res_illegal & (res_rd != '0);
    assign wb_rd    = res_rd;
    assign wb_value = res_value;

endmodule

`default_nettype wire

// File: tests/issue_core_checker.sv
// Handshake assertions for the issue pipeline top level, bound to issue_core

`timescale 1ns/1ps
`default_nettype none

module issue_core_checker (
    input wire                       clk,
    input wire                       rst,
    input wire                       in_valid,
    input wire                       in_ready,
    input wire                       res_valid,
    input wire                       res_ready,
    input wire issue_pkg::word_t     res_pc,
    input wire issue_pkg::reg_addr_t res_rd,
    input wire issue_pkg::word_t     res_value,
    input wire                       res_illegal
);

    int fail_count = 0;

    res_low_after_reset: assert property (@(posedge clk) rst |=> !res_valid)
        else begin
            fail_count = fail_count + 1;
            $error("res_valid high in the cycle after reset");
        end

    // Result held while the outside stalls
    res_stable: assert property (@(posedge clk) disable iff (rst)
        (res_valid && !res_ready) |=> (res_valid && $stable(res_pc) && $stable(res_rd) &&
                                       $stable(res_value) && $stable(res_illegal)))
        else begin
            fail_count = fail_count + 1;
            $error("Result changed while stalled");
        end

    // Decode drops ready only right after taking an item
    ready_falls_on_accept: assert property (@(posedge clk) disable iff (rst)
        $fell(in_ready) |-> $past(in_valid && in_ready))
        else begin
            fail_count = fail_count + 1;
            $error("in_ready fell without an accepted instruction");
        end

endmodule

bind issue_core issue_core_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .res_valid   (res_valid),
    .res_ready   (res_ready),
    .res_pc      (res_pc),
    .res_rd      (res_rd),
    .res_value   (res_value),
    .res_illegal (res_illegal)
);

`default_nettype wire

// File: tests/issue_monitor.sv
// Result monitor for the issue pipeline
// Expected-result queue, in-order compare and error counts

`timescale 1ns/1ps
`default_nettype none

module issue_monitor (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       res_valid,
    input  wire                       res_ready,
    input  wire issue_pkg::word_t     res_pc,
    input  wire issue_pkg::reg_addr_t res_rd,
    input  wire issue_pkg::word_t     res_value,
    input  wire                       res_illegal,
    output int                        mismatch_count,
    output int                        received_count,
    output int                        excess_count
);

    issue_pkg::word_t     exp_pc [$];
    logic                 exp_ill [$];
    issue_pkg::reg_addr_t exp_rd [$];
    issue_pkg::word_t     exp_val [$];

    int n_mismatch = 0;
    int n_received = 0;
    int n_excess   = 0;

    assign mismatch_count = n_mismatch;
    assign received_count = n_received;
    assign excess_count   = n_excess;

    task automatic add_expected(input issue_pkg::word_t pc, input logic ill,
                                input issue_pkg::reg_addr_t rd, input issue_pkg::word_t value);
        exp_pc.push_back(pc);
        exp_ill.push_back(ill);
        exp_rd.push_back(rd);
        exp_val.push_back(value);
    endtask

    // Accepted result, oldest expectation first
    always @(posedge clk) begin
        issue_pkg::word_t     e_pc;
        logic                 e_ill;
        issue_pkg::reg_addr_t e_rd;
        issue_pkg::word_t     e_val;
        if (!rst && res_valid && res_ready) begin
            n_received = n_received + 1;
            if (exp_pc.size() == 0) begin
                n_excess = n_excess + 1;
                $display("Extra result at time %0t for pc %h with no instruction to match",
                         $time, res_pc);
            end else begin
                e_pc  = exp_pc.pop_front();
                e_ill = exp_ill.pop_front();
                e_rd  = exp_rd.pop_front();
                e_val = exp_val.pop_front();
                if (res_pc !== e_pc || res_illegal !== e_ill ||
                    res_rd !== e_rd || res_value !== e_val) begin
                    n_mismatch = n_mismatch + 1;
                    $display("ERROR at %0t: pc %h ill %b rd %0d value %h, %s",
                             $time, res_pc, res_illegal, res_rd, res_value,
                             $sformatf("expected pc %h ill %b rd %0d value %h",
                                       e_pc, e_ill, e_rd, e_val));
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/issue_stim.txt
# Columns: instr(hex) pc(hex) illegal rd value(hex)
# Immediate ops, register ops on fresh results, lui/auipc, illegal ops, x0 writes
00500093 00000000 0 1  00000005
ffd00113 00000004 0 2  fffffffd
00112193 00000008 0 3  00000001
00113213 0000000c 0 4  00000000
0ff0c293 00000010 0 5  000000fa
0300e313 00000014 0 6  00000035
0f017393 00000018 0 7  000000f0
00409413 0000001c 0 8  00000050
00415493 00000020 0 9  0fffffff
40415513 00000024 0 10 ffffffff
002085b3 00000028 0 11 00000002
40158633 0000002c 0 12 fffffffd
401656b3 00000030 0 13 ffffffff
00d0b733 00000034 0 14 00000001
0016a7b3 00000038 0 15 00000001
00e09833 0000003c 0 16 0000000a
0016d8b3 00000040 0 17 07ffffff
00584933 00000044 0 18 000000f0
001969b3 00000048 0 19 000000f5
0079fa33 0000004c 0 20 000000f0
12345ab7 00000050 0 21 12345000
00001b17 00000054 0 22 00001054
00002083 00000058 1 0  00000000
00008b93 0000005c 0 23 00000005
00708013 00000060 0 0  0000000c
00000c33 00000064 0 24 00000000
00000063 00000068 1 0  00000000
02108cb3 0000006c 1 0  00000000

// File: tests/tb_issue_core.sv
// Testbench top for the issue pipeline
// Clock, reset, stimulus from the data file, random back-pressure, watchdog, verdict

`timescale 1ns/1ps
`default_nettype none

module tb_issue_core;

    localparam int          CLK_PERIOD       = 100;
    localparam int          CYCLES_PER_ENTRY = 40;
    localparam logic [31:0] LFSR_SEED        = 32'h55b6;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    issue_pkg::word_t     in_instr;
    issue_pkg::word_t     in_pc;
    logic                 in_ready;
    logic                 res_valid;
    issue_pkg::word_t     res_pc;
    issue_pkg::reg_addr_t res_rd;
    issue_pkg::word_t     res_value;
    logic                 res_illegal;
    logic                 res_ready;

    issue_pkg::word_t stim_instr [$];
    issue_pkg::word_t stim_pc [$];
    int               n_entries;
    logic             loaded;
    logic [31:0]      drive_lfsr;
    logic [31:0]      ready_lfsr;

    int mismatch_count;
    int received_count;
    int excess_count;

    issue_core u_issue_core (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_pc       (in_pc),
        .in_ready    (in_ready),
        .res_valid   (res_valid),
        .res_pc      (res_pc),
        .res_rd      (res_rd),
        .res_value   (res_value),
        .res_illegal (res_illegal),
        .res_ready   (res_ready)
    );

    issue_monitor u_monitor (
        .clk            (clk),
        .rst            (rst),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .res_pc         (res_pc),
        .res_rd         (res_rd),
        .res_value      (res_value),
        .res_illegal    (res_illegal),
        .mismatch_count (mismatch_count),
        .received_count (received_count),
        .excess_count   (excess_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR, taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic take_drive_bit(output logic b);
        b = drive_lfsr[0];
        drive_lfsr = lfsr_next(drive_lfsr);
    endtask

    task automatic take_ready_bit(output logic b);
        b = ready_lfsr[0];
        ready_lfsr = lfsr_next(ready_lfsr);
    endtask

    ////////////////////////////////////////
    // Stimulus file
    // Columns: instr pc illegal rd value
    task automatic load_stim(output logic open_ok);
        int                   fd;
        int                   n_fields;
        string                line;
        logic [31:0]          instr;
        logic [31:0]          pc;
        logic [31:0]          value;
        int                   ill;
        int                   rd;
        fd = $fopen("tests/issue_stim.txt", "r");
        open_ok = (fd != 0);
        if (open_ok) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n_fields = $sscanf(line, "%h %h %d %d %h", instr, pc, ill, rd, value);
                    if (n_fields == 5) begin
                        stim_instr.push_back(instr);
                        stim_pc.push_back(pc);
                        u_monitor.add_expected(pc, ill[0], rd[4:0], value);
                    end
                end
            end
            $fclose(fd);
        end
        n_entries = stim_instr.size();
    endtask

    // Up to 3 idle cycles, then hold until accepted
    task automatic send_instr(input issue_pkg::word_t instr, input issue_pkg::word_t pc);
        logic b0;
        logic b1;
        logic accepted;
        take_drive_bit(b0);
        take_drive_bit(b1);
        in_valid = 1'b0;
        repeat (int'({b1, b0})) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_instr = instr;
        in_pc    = pc;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        logic open_ok;
        int   missing;
        int   assert_errors;
        int   drain;
        clk        = 1'b0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_instr   = '0;
        in_pc      = '0;
        res_ready  = 1'b0;
        loaded     = 1'b0;
        n_entries  = 0;
        drive_lfsr = LFSR_SEED;
        ready_lfsr = LFSR_SEED;
        load_stim(open_ok);
        if (!open_ok) begin
            $display("Could not open the stimulus file tests/issue_stim.txt");
            $display("Result: FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (2) @(posedge clk);
            #1;
            rst = 1'b0;
            foreach (stim_instr[i]) begin
                send_instr(stim_instr[i], stim_pc[i]);
            end
            // Pipeline drain, bounded
            drain = 0;
            while (received_count < n_entries && drain < CYCLES_PER_ENTRY) begin
                @(posedge clk);
                drain = drain + 1;
            end
            // Leave room for any extra result
            repeat (10) @(posedge clk);
            missing = (received_count < n_entries) ? n_entries - received_count : 0;
            if (missing > 0) begin
                $display("%0d expected results never arrived", missing);
            end
            assert_errors = u_issue_core.u_checker.fail_count;
            $display("Errors: %0d mismatched, %0d missing, %0d excess, %0d assertion",
                     mismatch_count, missing, excess_count, assert_errors);
            if (mismatch_count + missing + excess_count + assert_errors == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

    // Random back-pressure, ready three cycles in four on average
    initial begin
        logic b0;
        logic b1;
        forever begin
            @(posedge clk);
            #1;
            take_ready_bit(b0);
            take_ready_bit(b1);
            res_ready = b0 | b1;
        end
    end

    // Watchdog
    initial begin
        wait (loaded);
        repeat ((n_entries + 1) * CYCLES_PER_ENTRY) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles",
                 (n_entries + 1) * CYCLES_PER_ENTRY);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
